// File: include/inert_cfg.svh
`ifndef INERT_CFG_SVH
`define INERT_CFG_SVH

// power-up wait, ends when the timer reads all ones
`define INERT_INIT_BITS 16

// system clocks per SCLK half period
`define INERT_SCLK_DIV 8

// 2^3 = 8 samples averaged into the zero-rate offset
`define INERT_CAL_SAMPLES_LOG2 3

`define INERT_RATE_SHIFT 4    // corrected rate >>> this before accumulation

`define INERT_NUM_AXES 3      // pitch, roll, yaw

`endif

// File: inert_sub.f
+incdir+include
verilog/inert_pkg.sv
verilog/spi_mnrch.sv
verilog/inert_intf.sv
verilog/axis_integrator.sv
verilog/angle_collector.sv
verilog/inert_top.sv
tests/sensor_model.sv
tests/inert_checker.sv
tests/inert_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the inert_tb simulation with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module inert_tb \
    -f inert_sub.f --Mdir obj_dir -o inert_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/inert_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "No errors"; then
    exit 0
fi
echo "simulation reported failure"
exit 1

// File: tests/inert_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "inert_cfg.svh"

module inert_checker import inert_pkg::*; #(
    parameter logic [31:0] SEED = 32'h1,
    parameter logic [47:0] BIAS = '0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       strt_cal,
    input  logic       INT,
    input  logic       SS_n,
    input  logic       SCLK,
    input  logic       MOSI,
    input  angle_set_t angles,
    input  logic       vld,
    input  logic       cal_done,
    input  logic       fin,            // end of stimulus
    output int         errors,
    output int         checks
);

    localparam int CAL_N = 2 ** `INERT_CAL_SAMPLES_LOG2;
    localparam logic [63:0] INIT_WORDS = 64'h0d02_1062_1162_1460;

    logic [31:0] rnd = SEED;
    logic [15:0] rx;
    int          bit_cnt;
    bit          in_frame;
    int          frame_idx;            // frames since reset
    int          rd_idx;               // position inside a read group
    int          int_rises;
    int          groups;
    int          vld_cnt;
    bit          cal_active;
    bit          int_q;
    rate_set_t   samples [$];          // samples since strt_cal

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic signed [15:0] rate_of(input logic [31:0] r, input int a);
        logic signed [15:0] noise;
        noise = r[15:0];
        return (noise >>> 6) + $signed(BIAS[47-16*a -: 16]);
    endfunction

    function automatic int axis_rate(input rate_set_t s, input int a);
        logic signed [15:0] v;
        v = s[47-16*a -: 16];
        return int'(v);
    endfunction

    //////////////////////////////////////////////////
    // expected angle set after sample n
    //////////////////////////////////////////////////
    function automatic angle_set_t ref_angles(input int n);
        int          sum [3];
        int          off [3];
        logic [15:0] ang [3];
        angle_set_t  res;
        for (int a = 0; a < 3; a++) begin
            sum[a] = 0;
            ang[a] = '0;
        end
        for (int i = 0; i < CAL_N; i++)
            for (int a = 0; a < 3; a++)
                sum[a] += axis_rate(samples[i], a);
        for (int a = 0; a < 3; a++)
            off[a] = sum[a] >>> `INERT_CAL_SAMPLES_LOG2;    // floor of the average
        for (int i = CAL_N; i <= n; i++)
            for (int a = 0; a < 3; a++)
                ang[a] = ang[a] + 16'((axis_rate(samples[i], a) - off[a]) >>> `INERT_RATE_SHIFT);
        res.ptch = ang[0];
        res.roll = ang[1];
        res.yaw  = ang[2];
        return res;
    endfunction

    task automatic report_value(input string name, input logic [47:0] got,
                                input logic [47:0] want);
        errors++;
        $display("FAIL %s got %0h expected %0h", name, got, want);
    endtask

    task automatic report_event(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_counts();
        int want;
        want = (samples.size() > CAL_N) ? samples.size() - CAL_N : 0;
        checks++;
        if (vld_cnt != want)
            report_event($sformatf("%0d vld pulses seen where %0d were due", vld_cnt, want));
        if (groups != int_rises)
            report_event($sformatf("%0d read groups for %0d INT pulses", groups, int_rises));
    endtask

    task automatic start_group();
        rate_set_t s;
        logic      want;
        checks++;
        if (groups >= int_rises)
            report_event("read group started without a new INT");
        want = cal_active && (samples.size() >= CAL_N);
        if (cal_done !== want)
            report_value("cal_done", 48'(cal_done), 48'(want));
        for (int a = 0; a < 3; a++) begin   // same draw order as the sensor
            rnd = xorshift(rnd);
            s[47-16*a -: 16] = rate_of(rnd, a);
        end
        if (cal_active)
            samples.push_back(s);
        groups++;
    endtask

    task automatic decode_frame();
        logic [15:0] want;
        checks++;
        if (bit_cnt != 16)
            report_event($sformatf("SPI frame had %0d bits instead of 16", bit_cnt));
        if (frame_idx < 4)
            want = INIT_WORDS[63-16*frame_idx -: 16];
        else
            want = {8'ha2 + 8'(rd_idx), 8'h00};
        if (rx !== want)
            report_value("MOSI", 48'(rx), 48'(want));
        if (frame_idx >= 4) begin
            if (rd_idx == 0)
                start_group();
            rd_idx = (rd_idx + 1) % 6;
        end
        frame_idx++;
    endtask

    task automatic check_angles();
        angle_set_t want;
        checks++;
        if (!cal_active || vld_cnt + CAL_N >= samples.size()) begin
            report_event("vld pulsed with no calibrated read group pending");
        end else begin
            want = ref_angles(vld_cnt + CAL_N);
            if (angles !== want)
                report_value("angles", angles, want);
        end
        if (cal_done !== 1'b1)
            report_value("cal_done", 48'(cal_done), 48'h1);
        vld_cnt++;
    endtask

    //////////////////////////////////////////////////
    // MOSI frames decoded at the pins
    //////////////////////////////////////////////////
    always @(negedge SS_n) begin
        in_frame = 1'b1;
        bit_cnt  = 0;
    end

    always @(posedge SCLK) begin
        if (!SS_n) begin
            rx = {rx[14:0], MOSI};
            bit_cnt++;
        end else if (rst_n === 1'b1) begin
            report_event("SCLK toggled while SS_n was high");
        end
    end

    always @(posedge SS_n) begin
        if (in_frame) begin
            in_frame = 1'b0;
            decode_frame();
        end
    end

    always @(posedge clk) begin
        if (rst_n === 1'b1) begin
            if (INT && !int_q)
                int_rises++;
            int_q = INT;
            if (strt_cal) begin         // angles restart from a new offset
                samples.delete();
                cal_active = 1'b1;
                vld_cnt    = 0;
            end
            if (vld)
                check_angles();
        end
    end

    always @(negedge rst_n) begin
        check_counts();
        samples.delete();
        cal_active = 1'b0;
        in_frame   = 1'b0;
        int_q      = 1'b0;
        frame_idx  = 0;
        rd_idx     = 0;
        int_rises  = 0;
        groups     = 0;
        vld_cnt    = 0;
    end

    always @(posedge fin) check_counts();

endmodule

`default_nettype wire

// File: tests/inert_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "inert_cfg.svh"

module inert_tb import inert_pkg::*; ;

    localparam int CLK_PERIOD    = 100;
    localparam int FRAME_CYC     = 32 * `INERT_SCLK_DIV + 2;
    localparam int INIT_CYC      = 2 ** `INERT_INIT_BITS;
    localparam int INT_PER_PHASE = 12;
    localparam int INT_TOTAL     = 2 * INT_PER_PHASE;
    localparam int QUIET_CYC     = 16 * FRAME_CYC;    // INT held low
    localparam longint WATCHDOG_CYC = longint'(INT_TOTAL + 4) * 8 * FRAME_CYC + 2 * INIT_CYC;
    localparam logic [31:0] SEED = 32'he4fb_3750;
    localparam logic [47:0] BIAS = {16'h0078, 16'hffb5, 16'h0021};   // +120, -75, +33

    logic       clk;
    logic       rst_n;
    logic       strt_cal;
    logic       INT;
    logic       MISO;
    logic       SS_n;
    logic       SCLK;
    logic       MOSI;
    angle_set_t angles;
    logic       vld;
    logic       cal_done;
    logic       fin;
    int         errors;
    int         checks;

    inert_top inert_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .strt_cal (strt_cal),
        .INT      (INT),
        .MISO     (MISO),
        .SS_n     (SS_n),
        .SCLK     (SCLK),
        .MOSI     (MOSI),
        .angles   (angles),
        .vld      (vld),
        .cal_done (cal_done)
    );

    sensor_model #(.SEED(SEED), .BIAS(BIAS)) sensor_model_i (
        .SS_n (SS_n),
        .SCLK (SCLK),
        .MOSI (MOSI),
        .MISO (MISO)
    );

    inert_checker #(.SEED(SEED), .BIAS(BIAS)) inert_checker_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .strt_cal (strt_cal),
        .INT      (INT),
        .SS_n     (SS_n),
        .SCLK     (SCLK),
        .MOSI     (MOSI),
        .angles   (angles),
        .vld      (vld),
        .cal_done (cal_done),
        .fin      (fin),
        .errors   (errors),
        .checks   (checks)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // four config frames, then the zero-rate strobe settles
    task automatic wait_init();
        repeat (4) @(posedge SS_n);
        repeat (4) @(posedge clk);
    endtask

    task automatic pulse_cal();
        strt_cal <= 1'b1;
        @(posedge clk);
        strt_cal <= 1'b0;
    endtask

    // one data-ready event, held until the six reads are through
    task automatic pulse_int();
        @(posedge clk);
        INT <= 1'b1;
        repeat (4) @(posedge clk);
        INT <= 1'b0;
        repeat (6) @(posedge SS_n);
        repeat (FRAME_CYC) @(posedge clk);
    endtask

    task automatic run_phase(input int n);
        wait_init();
        pulse_cal();
        repeat (n) pulse_int();
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    initial begin
        rst_n    = 1'b0;
        strt_cal = 1'b0;
        INT      = 1'b0;
        fin      = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        run_phase(INT_PER_PHASE);

        repeat (QUIET_CYC) @(posedge clk);  // sensor quiet, no frames expected
        rst_n <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        run_phase(INT_PER_PHASE);

        fin <= 1'b1;
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("watchdog expired after %0d clock cycles, the DUT stopped responding",
                 WATCHDOG_CYC);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/sensor_model.sv
`timescale 1ns/10ps
`default_nettype none

module sensor_model import inert_pkg::*; #(
    parameter logic [31:0] SEED = 32'h1,
    parameter logic [47:0] BIAS = '0     // pitch, roll, yaw zero-rate bias
) (
    input  logic SS_n,
    input  logic SCLK,
    input  logic MOSI,
    output logic MISO
);

    logic [7:0]  regs [0:127];
    logic [31:0] rnd;
    logic [15:0] rx;
    logic [7:0]  tx_byte;
    int          bit_cnt;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // small noise around a fixed bias per axis
    function automatic logic signed [15:0] rate_of(input logic [31:0] r, input int a);
        logic signed [15:0] noise;
        noise = r[15:0];
        return (noise >>> 6) + $signed(BIAS[47-16*a -: 16]);
    endfunction

    // new pitch, roll, yaw sample into the rate registers
    task automatic load_rates();
        logic signed [15:0] r;
        for (int a = 0; a < 3; a++) begin
            rnd = xorshift(rnd);
            r = rate_of(rnd, a);
            regs[8'h22 + 2*a] = r[7:0];
            regs[8'h23 + 2*a] = r[15:8];
        end
    endtask

    initial begin
        rnd     = SEED;
        MISO    = 1'b1;
        bit_cnt = 0;
        for (int i = 0; i < 128; i++)
            regs[i] = 8'(i) ^ 8'h5a;
    end

    //////////////////////////////////////////////////
    // SPI slave, mode 3
    //////////////////////////////////////////////////
    always @(negedge SS_n) begin
        bit_cnt = 0;
        rx      = '0;
    end

    always @(posedge SCLK) begin
        if (!SS_n) begin
            rx = {rx[14:0], MOSI};
            bit_cnt++;
            if (bit_cnt == 8) begin
                if (rx[7:0] == cmd_rd_ptch_l)   // a read group begins
                    load_rates();
                tx_byte = rx[7] ? regs[rx[6:0]] : 8'h00;
            end
            if (bit_cnt == 16 && !rx[15])
                regs[rx[14:8]] = rx[7:0];       // config write
        end
    end

    // data byte goes out msb first, changing on falling SCLK
    always @(negedge SCLK) begin
        if (!SS_n && bit_cnt >= 8 && bit_cnt < 16)
            MISO <= tx_byte[15 - bit_cnt];
    end

endmodule

`default_nettype wire

// File: verilog/angle_collector.sv
`timescale 1ns/10ps
`default_nettype none
`include "inert_cfg.svh"

module angle_collector import inert_pkg::*; #(
    parameter int NUM_AXES = `INERT_NUM_AXES
) (
    input  logic                clk,
    input  logic                rst_n,
    input  angle_set_t          ang_in,
    input  logic [NUM_AXES-1:0] ang_vld,
    input  logic [NUM_AXES-1:0] cal_ok,
    output angle_set_t          angles,
    output logic                vld,
    output logic                cal_done
);

    logic all_vld;

    // integrators share rate_vld, so their strobes line up
    assign all_vld = &ang_vld;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            vld      <= 1'b0;
            cal_done <= 1'b0;
        end else begin
            vld      <= all_vld;
            cal_done <= &cal_ok;        // every axis has its offset
        end
    end

    always_ff @(posedge clk) begin
        if (all_vld)
            angles <= ang_in;
    end

endmodule

`default_nettype wire

// File: verilog/axis_integrator.sv
`timescale 1ns/10ps
`default_nettype none
`include "inert_cfg.svh"

module axis_integrator (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               strt_cal,
    input  logic               rate_vld,
    input  logic signed [15:0] rate,
    output logic signed [15:0] angle,
    output logic               ang_vld,
    output logic               cal_ok
);

    localparam int CAL_LOG2 = `INERT_CAL_SAMPLES_LOG2;
    localparam int ACC_W    = 16 + CAL_LOG2;

    logic                cal_run;   // collecting offset samples
    logic [CAL_LOG2-1:0] smp_cnt;
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] acc_nxt;
    logic signed [15:0]  offset;
    logic signed [16:0]  rate_cor;  // one extra bit so rate - offset cannot wrap
    logic signed [16:0]  rate_shft;
    logic                last_smp;

    assign acc_nxt   = acc + ACC_W'(rate);
    assign last_smp  = cal_run && rate_vld && (&smp_cnt) && !strt_cal;
    assign rate_cor  = 17'(rate) - 17'(offset);
    assign rate_shft = rate_cor >>> `INERT_RATE_SHIFT;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            cal_run <= 1'b0;
            cal_ok  <= 1'b0;
            smp_cnt <= '0;
            angle   <= '0;
            ang_vld <= 1'b0;
        end else begin
            ang_vld <= rate_vld && cal_ok && !strt_cal;
            if (strt_cal) begin
                cal_run <= 1'b1;
                cal_ok  <= 1'b0;
                smp_cnt <= '0;
                angle   <= '0;
            end else if (rate_vld && cal_run) begin
                smp_cnt <= smp_cnt + 1'b1;
                if (last_smp) begin
                    cal_run <= 1'b0;
                    cal_ok  <= 1'b1;
                end
            end else if (rate_vld && cal_ok) begin
                angle <= angle + rate_shft[15:0];   // 16-bit wrap
            end
        end
    end

    always_ff @(posedge clk) begin
        if (strt_cal)
            acc <= '0;
        else if (rate_vld && cal_run)
            acc <= acc_nxt;
        if (last_smp)
            offset <= acc_nxt[CAL_LOG2 +: 16];      // average of the samples
    end

endmodule

`default_nettype wire

// File: verilog/inert_intf.sv
`timescale 1ns/10ps
`default_nettype none
`include "inert_cfg.svh"

module inert_intf import inert_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      INT,          // data ready from the sensor
    input  logic      MISO,
    output logic      SS_n,
    output logic      SCLK,
    output logic      MOSI,
    output rate_set_t rates,
    output logic      rate_vld
);

    intf_state_e state, nxt_state;
    sensor_cmd_e cmd_op;
    logic [7:0]  cmd_arg;
    logic [15:0] wt_data;
    logic [15:0] rd_data;
    logic        wrt;
    logic        done;
    logic [5:0]  cap;               // ptch l/h, roll l/h, yaw l/h

    logic [`INERT_INIT_BITS-1:0] init_tmr;
    logic int_ff1, int_ff2;

    assign wt_data = {cmd_op, cmd_arg};

    spi_mnrch spi_mnrch_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wrt     (wrt),
        .wt_data (wt_data),
        .MISO    (MISO),
        .SS_n    (SS_n),
        .SCLK    (SCLK),
        .MOSI    (MOSI),
        .done    (done),
        .rd_data (rd_data)
    );

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            state <= init_int;
        else
            state <= nxt_state;
    end

    //////////////////////////////////////////////////
    // sequencing, cmd is the frame issued on leaving
    //////////////////////////////////////////////////
    always_comb begin
        nxt_state = state;
        wrt       = 1'b0;
        rate_vld  = 1'b0;
        cap       = '0;
        cmd_op    = cmd_rd_ptch_l;
        cmd_arg   = 8'h00;
        case (state)
            init_int: begin
                cmd_op  = cmd_int_cfg;
                cmd_arg = 8'h02;
                if (&init_tmr) begin    // sensor has finished its own init
                    wrt       = 1'b1;
                    nxt_state = init_accel_rate;
                end
            end
            init_accel_rate: begin
                cmd_op  = cmd_accel_cfg;
                cmd_arg = 8'h62;
                if (done) begin
                    wrt       = 1'b1;
                    nxt_state = init_gyro_rate;
                end
            end
            init_gyro_rate: begin
                cmd_op  = cmd_gyro_cfg;
                cmd_arg = 8'h62;
                if (done) begin
                    wrt       = 1'b1;
                    nxt_state = init_round;
                end
            end
            init_round: begin
                cmd_op  = cmd_round_cfg;
                cmd_arg = 8'h60;
                if (done) begin
                    wrt       = 1'b1;
                    nxt_state = issue_vld;
                end
            end
            rd_ptch_l: begin
                cmd_op = cmd_rd_ptch_h;
                if (done) begin
                    cap[0]    = 1'b1;
                    wrt       = 1'b1;
                    nxt_state = rd_ptch_h;
                end
            end
            rd_ptch_h: begin
                cmd_op = cmd_rd_roll_l;
                if (done) begin
                    cap[1]    = 1'b1;
                    wrt       = 1'b1;
                    nxt_state = rd_roll_l;
                end
            end
            rd_roll_l: begin
                cmd_op = cmd_rd_roll_h;
                if (done) begin
                    cap[2]    = 1'b1;
                    wrt       = 1'b1;
                    nxt_state = rd_roll_h;
                end
            end
            rd_roll_h: begin
                cmd_op = cmd_rd_yaw_l;
                if (done) begin
                    cap[3]    = 1'b1;
                    wrt       = 1'b1;
                    nxt_state = rd_yaw_l;
                end
            end
            rd_yaw_l: begin
                cmd_op = cmd_rd_yaw_h;
                if (done) begin
                    cap[4]    = 1'b1;
                    wrt       = 1'b1;
                    nxt_state = rd_yaw_h;
                end
            end
            rd_yaw_h: begin
                if (done) begin         // last byte, no further frame
                    cap[5]    = 1'b1;
                    nxt_state = issue_vld;
                end
            end
            issue_vld: begin
                if (done) begin
                    rate_vld  = 1'b1;
                    nxt_state = idle;
                end
            end
            default: begin              // idle, wait for data ready
                cmd_op = cmd_rd_ptch_l;
                if (int_ff2 && done) begin
                    wrt       = 1'b1;
                    nxt_state = rd_ptch_l;
                end
            end
        endcase
    end

    // returned register value sits in the low byte
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            rates <= '0;
        end else begin
            if (cap[0])
                rates.ptch_rt[7:0] <= rd_data[7:0];
            if (cap[1])
                rates.ptch_rt[15:8] <= rd_data[7:0];
            if (cap[2])
                rates.roll_rt[7:0] <= rd_data[7:0];
            if (cap[3])
                rates.roll_rt[15:8] <= rd_data[7:0];
            if (cap[4])
                rates.yaw_rt[7:0] <= rd_data[7:0];
            if (cap[5])
                rates.yaw_rt[15:8] <= rd_data[7:0];
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            init_tmr <= '0;
        else if (state == init_int)
            init_tmr <= init_tmr + 1'b1;
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            int_ff1 <= 1'b0;
            int_ff2 <= 1'b0;
        end else begin
            int_ff1 <= INT;             // async from the sensor
            int_ff2 <= int_ff1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/inert_pkg.sv
`default_nettype none

package inert_pkg;

    // sensor sequencing states
    typedef enum logic [3:0] {
        init_int,
        init_gyro_rate,
        init_accel_rate,
        init_round,
        rd_ptch_l,
        rd_ptch_h,
        rd_roll_l,
        rd_roll_h,
        rd_yaw_l,
        rd_yaw_h,
        issue_vld,
        idle
    } intf_state_e;

    // upper byte of an SPI frame: config writes, then read bit + address
    typedef enum logic [7:0] {
        cmd_int_cfg   = 8'h0D,    // data-ready on INT
        cmd_accel_cfg = 8'h10,
        cmd_gyro_cfg  = 8'h11,
        cmd_round_cfg = 8'h14,
        cmd_rd_ptch_l = 8'hA2,
        cmd_rd_ptch_h = 8'hA3,
        cmd_rd_roll_l = 8'hA4,
        cmd_rd_roll_h = 8'hA5,
        cmd_rd_yaw_l  = 8'hA6,
        cmd_rd_yaw_h  = 8'hA7
    } sensor_cmd_e;

    typedef struct packed {
        logic signed [15:0] ptch_rt;
        logic signed [15:0] roll_rt;
        logic signed [15:0] yaw_rt;
    } rate_set_t;

    typedef struct packed {
        logic signed [15:0] ptch;
        logic signed [15:0] roll;
        logic signed [15:0] yaw;
    } angle_set_t;

endpackage

`default_nettype wire

// File: verilog/inert_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "inert_cfg.svh"

module inert_top import inert_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       strt_cal,
    input  logic       INT,
    input  logic       MISO,
    output logic       SS_n,
    output logic       SCLK,
    output logic       MOSI,
    output angle_set_t angles,
    output logic       vld,
    output logic       cal_done
);

    localparam int NUM_AXES = `INERT_NUM_AXES;

    rate_set_t  rates;
    angle_set_t ang_set;
    logic       rate_vld;
    logic [NUM_AXES-1:0][15:0] rate_arr;    // element NUM_AXES-1 is pitch
    logic [NUM_AXES-1:0][15:0] ang_arr;
    logic [NUM_AXES-1:0]       ang_vld;
    logic [NUM_AXES-1:0]       cal_ok;

    assign rate_arr = rates;
    assign ang_set  = ang_arr;

    inert_intf inert_intf_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .INT      (INT),
        .MISO     (MISO),
        .SS_n     (SS_n),
        .SCLK     (SCLK),
        .MOSI     (MOSI),
        .rates    (rates),
        .rate_vld (rate_vld)
    );

    // axis k takes pitch, roll, yaw in that order
    for (genvar k = 0; k < NUM_AXES; k++) begin : g_axis
        axis_integrator axis_integrator_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .strt_cal (strt_cal),
            .rate_vld (rate_vld),
            .rate     (rate_arr[NUM_AXES-1-k]),
            .angle    (ang_arr[NUM_AXES-1-k]),
            .ang_vld  (ang_vld[k]),
            .cal_ok   (cal_ok[k])
        );
    end

    angle_collector #(.NUM_AXES(NUM_AXES)) angle_collector_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ang_in   (ang_set),
        .ang_vld  (ang_vld),
        .cal_ok   (cal_ok),
        .angles   (angles),
        .vld      (vld),
        .cal_done (cal_done)
    );

endmodule

`default_nettype wire

// File: verilog/spi_mnrch.sv
`timescale 1ns/10ps
`default_nettype none
`include "inert_cfg.svh"

module spi_mnrch (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wrt,        // one-cycle frame start
    input  logic [15:0] wt_data,
    input  logic        MISO,
    output logic        SS_n,
    output logic        SCLK,
    output logic        MOSI,
    output logic        done,       // level, cleared by wrt
    output logic [15:0] rd_data
);

    localparam int DIV_W = $clog2(`INERT_SCLK_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic [5:0]       hp_cnt;       // SCLK half periods elapsed, 32 per frame
    logic             busy;
    logic [15:0]      shft;
    logic             miso_smp;
    logic             edge_en;      // SCLK toggles at the next clock
    logic             frame_end;

    assign edge_en   = busy && !hp_cnt[5] && (div_cnt == DIV_W'(`INERT_SCLK_DIV - 1));
    assign frame_end = busy && hp_cnt[5];

    assign MOSI    = shft[15];
    assign rd_data = shft;

    //////////////////////////////////////////////////
    // frame control, SCLK idles high (mode 3)
    //////////////////////////////////////////////////
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            SS_n    <= 1'b1;
            SCLK    <= 1'b1;
            done    <= 1'b0;
            div_cnt <= '0;
            hp_cnt  <= '0;
        end else if (wrt) begin
            busy    <= 1'b1;
            SS_n    <= 1'b0;
            SCLK    <= 1'b1;
            done    <= 1'b0;
            div_cnt <= '0;
            hp_cnt  <= '0;
        end else if (frame_end) begin
            busy <= 1'b0;               // one clock after the last rising edge
            SS_n <= 1'b1;
            done <= 1'b1;
        end else if (busy) begin
            div_cnt <= edge_en ? '0 : div_cnt + 1'b1;
            if (edge_en) begin
                SCLK   <= ~SCLK;
                hp_cnt <= hp_cnt + 6'd1;
            end
        end
    end

    // sample on rising SCLK, shift on falling SCLK
    // the first fall only opens the frame, the last bit shifts in at frame end
    always_ff @(posedge clk) begin
        if (wrt)
            shft <= wt_data;
        else if (edge_en && SCLK && (hp_cnt != 6'd0))
            shft <= {shft[14:0], miso_smp};
        else if (frame_end)
            shft <= {shft[14:0], miso_smp};

        if (edge_en && !SCLK)
            miso_smp <= MISO;
    end

endmodule

`default_nettype wire
